// ==== mem_cfg.svh ====
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// Address split is tag | index | offset, 5 + 8 + 3 bits

`define MEM_ADDR_W     16 // Byte address
`define MEM_WORD_W     16 // Data word

`define MEM_OFFSET_W   3  // Byte offset in an 8-byte line
`define MEM_INDEX_W    8  // 256 sets per way
`define MEM_TAG_W      5  // Upper address bits

`define MEM_LINE_WORDS 4  // Words per line

`define MEM_LATENCY    2  // Read strobe to data, in cycles
`define MEM_WORDS      32768 // Main memory depth in words

`endif

// ==== mem_pkg.sv ====
`include "mem_cfg.svh"

package mem_pkg;

	typedef logic [`MEM_ADDR_W-1:0]   addr_t;   // Byte address
	typedef logic [`MEM_WORD_W-1:0]   word_t;   // Data word
	typedef logic [`MEM_TAG_W-1:0]    tag_t;    // Line tag
	typedef logic [`MEM_INDEX_W-1:0]  index_t;  // Set number
	typedef logic [`MEM_OFFSET_W-1:0] offset_t; // Byte offset in line

	// Miss handling overlaps the last memory requests with the first fills
	typedef enum logic [3:0] {
		IDLE       = 4'd0,
		COMPARE    = 4'd1,
		ALLOC      = 4'd2,
		WB0        = 4'd3,
		WB1        = 4'd4,
		WB2        = 4'd5,
		WB3        = 4'd6,
		REQ0       = 4'd7,
		REQ1       = 4'd8,
		REQ2_FILL0 = 4'd9,
		REQ3_FILL1 = 4'd10,
		FILL2      = 4'd11,
		FILL3      = 4'd12,
		FINISH     = 4'd13
	} ctrl_state_t;

endpackage

// ==== cache_way.sv ====
`timescale 1ns/1ps
`include "mem_cfg.svh"

module cache_way
	import mem_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    enable,
	input  logic    comp,
	input  logic    write,
	input  index_t  index,
	input  offset_t offset,
	input  tag_t    tag_in,
	input  word_t   data_in,
	output logic    hit,
	output logic    valid,
	output logic    dirty,
	output tag_t    tag_out,
	output word_t   data_out
);

	localparam int SETS   = 2 ** `MEM_INDEX_W;
	localparam int WSEL_W = $clog2(`MEM_LINE_WORDS);

	word_t data_mem [SETS * `MEM_LINE_WORDS]; // Line words, set-major
	tag_t  tag_mem  [SETS];

	logic [SETS-1:0] valid_bits;
	logic [SETS-1:0] dirty_bits;

	logic [`MEM_INDEX_W+WSEL_W-1:0] word_addr;
	logic tag_match;
	logic wr_hit;
	logic wr_fill;

	// Byte bit of the offset is dropped, accesses are word aligned
	assign word_addr = {index, offset[WSEL_W:1]};

	// Reads are combinational
	assign data_out  = data_mem[word_addr];
	assign tag_out   = tag_mem[index];
	assign valid     = valid_bits[index];
	assign dirty     = dirty_bits[index];
	assign tag_match = (tag_mem[index] == tag_in);

	assign hit     = enable & comp & tag_match;
	assign wr_hit  = hit & valid & write;     // Compare mode store
	assign wr_fill = enable & ~comp & write;  // Access mode store

	always_ff @(posedge clk) begin
		if (wr_hit | wr_fill)
			data_mem[word_addr] <= data_in;
		if (wr_fill)
			tag_mem[index] <= tag_in;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end else if (wr_fill) begin
			valid_bits[index] <= 1'b1;
			dirty_bits[index] <= 1'b0; // Fresh line from memory
		end else if (wr_hit) begin
			dirty_bits[index] <= 1'b1;
		end
	end

endmodule

// ==== cache_controller.sv ====
`timescale 1ns/1ps
`include "mem_cfg.svh"

module cache_controller
	import mem_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       rd,
	input  logic       wr,
	input  addr_t      addr,
	input  word_t      data_in,
	input  logic [1:0] way_hit,
	input  logic [1:0] way_valid,
	input  logic [1:0] way_dirty,
	output addr_t      req_addr,
	output word_t      req_data,
	output logic [1:0] enable,
	output offset_t    offset,
	output logic       comp,
	output logic       write,
	output logic       data_src,
	output logic       tag_src,
	output logic       mem_rd,
	output logic       mem_wr,
	output offset_t    mem_offset,
	output logic       done,
	output logic       stall,
	output logic       cache_hit,
	output logic       err
);

	ctrl_state_t state;
	ctrl_state_t next_state;

	logic       req_wr;
	logic       victim;
	logic [1:0] way_sel;   // Way chosen in ALLOC
	logic [1:0] alloc_sel;
	logic       alloc_dirty;
	logic       any_hit;
	logic       start;
	offset_t    req_offset;

	// Offset of word w within the line
	function automatic offset_t word_off(input logic [1:0] w);
		return {w, 1'b0};
	endfunction

	assign start      = rd ^ wr; // Both high is an error, not a request
	assign req_offset = req_addr[`MEM_OFFSET_W-1:0];
	assign any_hit    = |(way_hit & way_valid);

	always_comb begin
		if (!way_valid[0])
			alloc_sel = 2'b01;
		else if (!way_valid[1])
			alloc_sel = 2'b10;
		else if (victim)
			alloc_sel = 2'b10;
		else
			alloc_sel = 2'b01;
		alloc_dirty = |(alloc_sel & way_valid & way_dirty);
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= IDLE;
		else
			state <= next_state;
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && start) begin
			req_addr <= addr;
			req_data <= data_in;
			req_wr   <= wr;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			victim  <= 1'b0;
			way_sel <= 2'b00;
		end else begin
			if (state == COMPARE)
				victim <= ~victim; // Alternates on every lookup
			if (state == ALLOC)
				way_sel <= alloc_sel;
		end
	end

	always_comb begin
		next_state = state;
		enable     = way_sel;
		offset     = req_offset;
		comp       = 1'b0;
		write      = 1'b0;
		data_src   = 1'b0;
		tag_src    = 1'b0;
		mem_rd     = 1'b0;
		mem_wr     = 1'b0;
		mem_offset = req_offset;
		done       = 1'b0;
		stall      = 1'b1;
		cache_hit  = 1'b0;
		err        = 1'b0;

		case (state)
			IDLE: begin
				enable = 2'b00;
				stall  = start;
				err    = rd & wr;
				if (start)
					next_state = COMPARE;
			end
			COMPARE: begin
				enable    = 2'b11; // Look up both ways
				comp      = 1'b1;
				write     = req_wr;
				done      = any_hit;
				cache_hit = any_hit;
				next_state = any_hit ? IDLE : ALLOC;
			end
			ALLOC: begin
				enable     = alloc_sel;
				next_state = alloc_dirty ? WB0 : REQ0;
			end
			WB0, WB1, WB2, WB3: begin
				offset     = word_off(2'(state - WB0));
				mem_offset = word_off(2'(state - WB0));
				tag_src    = 1'b1; // Victim line address
				mem_wr     = 1'b1;
				next_state = (state == WB3) ? REQ0 : ctrl_state_t'(state + 4'd1);
			end
			REQ0, REQ1: begin
				mem_rd     = 1'b1;
				mem_offset = word_off(2'(state - REQ0));
				next_state = ctrl_state_t'(state + 4'd1);
			end
			REQ2_FILL0, REQ3_FILL1: begin
				mem_rd     = 1'b1;
				mem_offset = word_off(2'(state - REQ0));
				offset     = word_off(2'(state - REQ2_FILL0));
				write      = 1'b1;
				data_src   = 1'b1;
				next_state = ctrl_state_t'(state + 4'd1);
			end
			FILL2, FILL3: begin
				offset     = word_off(2'(state - REQ2_FILL0));
				write      = 1'b1;
				data_src   = 1'b1;
				next_state = ctrl_state_t'(state + 4'd1);
			end
			FINISH: begin
				comp       = 1'b1; // Replay the access on the filled way
				write      = req_wr;
				done       = 1'b1;
				next_state = IDLE;
			end
			default: begin
				err        = 1'b1;
				next_state = IDLE;
			end
		endcase
	end

	a_enable_onehot: assert property (@(posedge clk) disable iff (reset)
		(state != IDLE && state != COMPARE) |-> $onehot(enable));

	// Filled way must hit when the access is replayed
	a_finish_hit: assert property (@(posedge clk) disable iff (reset)
		(state == FINISH) |-> |(way_hit & way_valid));

endmodule

// ==== main_memory.sv ====
`timescale 1ns/1ps
`include "mem_cfg.svh"

module main_memory
	import mem_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  rd,
	input  logic  wr,
	input  addr_t addr,
	input  word_t data_in,
	output word_t data_out,
	output logic  rd_valid
);

	localparam int WIDX_W = $clog2(`MEM_WORDS);
	localparam int LAT    = `MEM_LATENCY;

	word_t mem [`MEM_WORDS];

	word_t           rd_pipe  [LAT]; // Read data in flight
	logic  [LAT-1:0] vld_pipe;
	logic  [WIDX_W-1:0] word_addr;

	// Word addressed, byte bit ignored
	assign word_addr = addr[WIDX_W:1];

	always_ff @(posedge clk) begin
		if (wr)
			mem[word_addr] <= data_in;
	end

	always_ff @(posedge clk) begin
		rd_pipe[0] <= mem[word_addr];
		for (int i = 1; i < LAT; i++) begin
			rd_pipe[i] <= rd_pipe[i-1];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			vld_pipe <= '0;
		end else begin
			vld_pipe[0] <= rd;
			for (int i = 1; i < LAT; i++) begin
				vld_pipe[i] <= vld_pipe[i-1];
			end
		end
	end

	assign data_out = rd_pipe[LAT-1];
	assign rd_valid = vld_pipe[LAT-1];

	a_rd_wr_excl: assert property (@(posedge clk) disable iff (reset)
		!(rd && wr));

endmodule

// ==== mem_system.sv ====
`timescale 1ns/1ps
`include "mem_cfg.svh"

module mem_system
	import mem_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  rd,
	input  logic  wr,
	input  addr_t addr,
	input  word_t data_in,
	output word_t data_out,
	output logic  done,
	output logic  stall,
	output logic  cache_hit,
	output logic  err
);

	addr_t      req_addr;
	word_t      req_data;
	logic [1:0] enable;
	offset_t    offset;
	logic       comp;
	logic       write;
	logic       data_src;
	logic       tag_src;
	logic       mem_rd;
	logic       mem_wr;
	offset_t    mem_offset;

	logic [1:0] way_hit;
	logic [1:0] way_valid;
	logic [1:0] way_dirty;
	tag_t       way0_tag;
	tag_t       way1_tag;
	word_t      way0_data;
	word_t      way1_data;

	tag_t   req_tag;
	index_t req_index;
	tag_t   mem_tag;
	addr_t  mem_addr;
	word_t  way_wdata;
	word_t  mem_rdata;
	logic   mem_rd_valid;
	logic   sel1;       // Way 1 supplies the returned word

	assign req_tag   = req_addr[`MEM_ADDR_W-1 -: `MEM_TAG_W];
	assign req_index = req_addr[`MEM_OFFSET_W +: `MEM_INDEX_W];

	// Hitting way first, otherwise the single enabled way
	assign sel1 = (way_hit[1] & way_valid[1])
		| (enable == 2'b10 & ~(way_hit[0] & way_valid[0]));

	assign data_out  = sel1 ? way1_data : way0_data;
	assign mem_tag   = tag_src ? (sel1 ? way1_tag : way0_tag) : req_tag;
	assign mem_addr  = {mem_tag, req_index, mem_offset};
	assign way_wdata = data_src ? mem_rdata : req_data;

	cache_controller ctrl (
		.clk(clk), .reset(reset), .rd(rd), .wr(wr), .addr(addr), .data_in(data_in),
		.way_hit(way_hit), .way_valid(way_valid), .way_dirty(way_dirty),
		.req_addr(req_addr), .req_data(req_data), .enable(enable), .offset(offset),
		.comp(comp), .write(write), .data_src(data_src), .tag_src(tag_src),
		.mem_rd(mem_rd), .mem_wr(mem_wr), .mem_offset(mem_offset), .done(done),
		.stall(stall), .cache_hit(cache_hit), .err(err));

	cache_way way0 (
		.clk(clk), .reset(reset), .enable(enable[0]), .comp(comp), .write(write),
		.index(req_index), .offset(offset), .tag_in(req_tag), .data_in(way_wdata),
		.hit(way_hit[0]), .valid(way_valid[0]), .dirty(way_dirty[0]),
		.tag_out(way0_tag), .data_out(way0_data));

	cache_way way1 (
		.clk(clk), .reset(reset), .enable(enable[1]), .comp(comp), .write(write),
		.index(req_index), .offset(offset), .tag_in(req_tag), .data_in(way_wdata),
		.hit(way_hit[1]), .valid(way_valid[1]), .dirty(way_dirty[1]),
		.tag_out(way1_tag), .data_out(way1_data));

	main_memory mem (
		.clk(clk), .reset(reset), .rd(mem_rd), .wr(mem_wr), .addr(mem_addr),
		.data_in(data_out), .data_out(mem_rdata), .rd_valid(mem_rd_valid));

	// Fill data must line up with the memory read pipeline
	a_fill_aligned: assert property (@(posedge clk) disable iff (reset)
		(data_src && write) |-> mem_rd_valid);

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS    = 10,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Released just after an edge, like the other inputs
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 reset = 1'b0;
	end

endmodule

// ==== tb_mem_system.sv ====
`timescale 1ns/1ps
`include "mem_cfg.svh"

module tb_mem_system
	import mem_pkg::*;
();

	typedef enum logic [1:0] {OP_RD, OP_WR, OP_BOTH} op_t;
	typedef enum logic [1:0] {EXP_HIT, EXP_MISS, EXP_ANY} hit_class_t;
	typedef enum logic [1:0] {LAT_1, LAT_9, LAT_ANY} lat_class_t;

	typedef struct packed {
		op_t        op;
		addr_t      addr;
		word_t      data;
		hit_class_t hit_cls;
		lat_class_t lat_cls;
	} row_t;

	localparam int RANDOM_ROWS = 40;
	localparam int MAX_WAIT    = 20; // Dirty miss needs 13

	logic  clk;
	logic  reset;
	logic  rd;
	logic  wr;
	addr_t addr;
	word_t data_in;
	word_t data_out;
	logic  done;
	logic  stall;
	logic  cache_hit;
	logic  err;

	row_t  rows [$];
	word_t shadow [int]; // Last written word per word address
	int    errors;
	int    checks;
	bit    table_ready;

	tb_clock clkgen (.clk(clk), .reset(reset));

	mem_system UUT (
		.clk(clk), .reset(reset), .rd(rd), .wr(wr), .addr(addr), .data_in(data_in),
		.data_out(data_out), .done(done), .stall(stall), .cache_hit(cache_hit),
		.err(err));

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int word_index(input addr_t a);
		return int'(a[`MEM_ADDR_W-1:1]);
	endfunction

	function automatic int expected_cycles(input lat_class_t l);
		return (l == LAT_1) ? 1 : 9;
	endfunction

	task automatic check_value(input string where, input string name,
			input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("[ERROR] %s: %s = 0x%0h, expected 0x%0h", where, name, got, exp);
		end
	endtask

	task automatic add_row(input op_t op, input addr_t a, input word_t d,
			input hit_class_t h, input lat_class_t l);
		row_t r;
		r.op      = op;
		r.addr    = a;
		r.data    = d;
		r.hit_cls = h;
		r.lat_cls = l;
		rows.push_back(r);
	endtask

	task automatic build_table();
		// Cold reads
		add_row(OP_RD, 16'h0040, 16'h0000, EXP_MISS, LAT_9);
		add_row(OP_RD, 16'h0042, 16'h0000, EXP_HIT, LAT_1);
		add_row(OP_RD, 16'h0800, 16'h0000, EXP_MISS, LAT_9);
		// Write allocate, then hits in the same line
		add_row(OP_WR, 16'h0100, 16'ha5a5, EXP_MISS, LAT_9);
		add_row(OP_RD, 16'h0100, 16'h0000, EXP_HIT, LAT_1);
		add_row(OP_RD, 16'h0102, 16'h0000, EXP_HIT, LAT_1);
		add_row(OP_WR, 16'h0106, 16'h1234, EXP_HIT, LAT_1);
		add_row(OP_RD, 16'h0106, 16'h0000, EXP_HIT, LAT_1);
		add_row(OP_RD, 16'h0100, 16'h0000, EXP_HIT, LAT_1);
		// Tags 2 and 5 share set 0x30
		add_row(OP_WR, 16'h1180, 16'h1111, EXP_MISS, LAT_9);
		add_row(OP_WR, 16'h2980, 16'h2222, EXP_MISS, LAT_9);
		add_row(OP_RD, 16'h1180, 16'h0000, EXP_HIT, LAT_1);
		add_row(OP_RD, 16'h2980, 16'h0000, EXP_HIT, LAT_1);
		add_row(OP_RD, 16'h1180, 16'h0000, EXP_HIT, LAT_1);
		add_row(OP_WR, 16'h2982, 16'h2b2b, EXP_HIT, LAT_1);
		add_row(OP_RD, 16'h2982, 16'h0000, EXP_HIT, LAT_1);
		// Tag 9 evicts a dirty line of set 0x30
		add_row(OP_WR, 16'h4980, 16'h3333, EXP_ANY, LAT_ANY);
		add_row(OP_RD, 16'h1180, 16'h0000, EXP_ANY, LAT_ANY);
		add_row(OP_RD, 16'h2980, 16'h0000, EXP_ANY, LAT_ANY);
		add_row(OP_RD, 16'h4980, 16'h0000, EXP_ANY, LAT_ANY);
		add_row(OP_RD, 16'h2982, 16'h0000, EXP_ANY, LAT_ANY);
		// Illegal strobe must leave the line untouched
		add_row(OP_BOTH, 16'h0100, 16'hffff, EXP_ANY, LAT_ANY);
		add_row(OP_RD, 16'h0100, 16'h0000, EXP_HIT, LAT_1);
	endtask

	task automatic add_random_rows(input int count);
		logic [31:0] seed;
		addr_t       a;
		op_t         op;
		seed = 32'h23d1;
		for (int i = 0; i < count; i++) begin
			seed = xorshift32(seed);
			// Four tags over sets 0x50 and 0x51
			a  = {3'b000, seed[1:0], 7'b0101000, seed[2], seed[4:3], 1'b0};
			op = seed[5] ? OP_WR : OP_RD;
			add_row(op, a, seed[31:16], EXP_ANY, LAT_ANY);
		end
	endtask

	task automatic check_bad_strobe(input string where);
		check_value(where, "err", 32'(err), 1);
		check_value(where, "stall", 32'(stall), 0);
		for (int i = 0; i < 3; i++) begin
			@(posedge clk);
			#1;
			rd = 1'b0;
			wr = 1'b0;
			#4;
			check_value(where, "done", 32'(done), 0);
			check_value(where, "stall", 32'(stall), 0); // Still idle
			check_value(where, "err", 32'(err), 0);
		end
	endtask

	task automatic run_row(input int n, input row_t r);
		string where;
		int    cycle;
		where = $sformatf("row %0d", n);
		@(posedge clk);
		#1;
		rd      = (r.op != OP_WR);
		wr      = (r.op != OP_RD);
		addr    = r.addr;
		data_in = r.data;
		#4;
		if (r.op == OP_BOTH) begin
			check_bad_strobe(where);
		end else begin
			check_value(where, "stall", 32'(stall), 1); // Combinational in cycle 0
			cycle = 0;
			do begin
				@(posedge clk);
				#1;
				rd = 1'b0;
				wr = 1'b0;
				#4;
				cycle++;
				check_value(where, "stall", 32'(stall), 1);
				check_value(where, "err", 32'(err), 0);
			end while (!done && cycle < MAX_WAIT);
			assert (done) else begin
				errors++;
				$display("Row %0d got no done within %0d cycles", n, cycle);
			end
			if (done) begin
				if (r.lat_cls != LAT_ANY)
					check_value(where, "latency", cycle, expected_cycles(r.lat_cls));
				if (r.hit_cls != EXP_ANY)
					check_value(where, "cache_hit", 32'(cache_hit),
						32'(r.hit_cls == EXP_HIT));
				if (r.op == OP_RD && shadow.exists(word_index(r.addr)))
					check_value(where, "data_out", 32'(data_out),
						32'(shadow[word_index(r.addr)]));
				if (r.op == OP_WR)
					shadow[word_index(r.addr)] = r.data;
			end
		end
	endtask

	initial begin
		rd          = 1'b0;
		wr          = 1'b0;
		addr        = '0;
		data_in     = '0;
		errors      = 0;
		checks      = 0;
		table_ready = 1'b0;
		build_table();
		add_random_rows(RANDOM_ROWS);
		table_ready = 1'b1;

		@(negedge reset);
		@(posedge clk);
		#5;
		check_value("after reset", "done", 32'(done), 0);
		check_value("after reset", "stall", 32'(stall), 0);
		check_value("after reset", "cache_hit", 32'(cache_hit), 0);
		check_value("after reset", "err", 32'(err), 0);

		for (int i = 0; i < rows.size(); i++) begin
			run_row(i, rows[i]);
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	// Bound from the table length, plus reset and slack
	initial begin : watchdog
		wait (table_ready);
		repeat (rows.size() * MAX_WAIT + 100) @(posedge clk);
		$display("Watchdog expired, the run did not finish in time");
		$display("Checks: %0d, errors: %0d", checks, errors);
		$display("test failed");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+.
mem_pkg.sv
cache_way.sv
cache_controller.sv
main_memory.sv
mem_system.sv
tb_clock.sv
tb_mem_system.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps \
	-f sim.f --top-module tb_mem_system -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "test failed" sim.log; then
	exit 1
fi
exit 0
